// File: hwag.f
verilog/hwag_pkg.sv
verilog/hwag_regs.sv
verilog/vr_capture.sv
verilog/tooth_timing.sv
verilog/angle_gen.sv
verilog/ign_output.sv
verilog/hwag.sv
verif/hwag_tb.sv

// File: verif/hwag_input.txt
# Angle generator testbench settings and expected values
# Columns: name value (decimal), lines starting with # are skipped
flt_len 4
glitch_len 3
pulse_len 9
min_per 48
max_per 80
teeth_num 10
ang_shift 3
ign_on 20
ign_off 44
# Tooth period in clocks and extra random clocks per tooth
period 64
jitter 3
ign_revs 3
cnt_reads 8
# PER after a stable tooth, ignition high time in clocks
exp_per 64
exp_high 192

// File: verif/hwag_tb.sv
// Testbench for the angle generator: registers, filter, lock, loss and ignition
// Settings and expected values are read from verif/hwag_input.txt
`timescale 1ns/1ps
`default_nettype none

module hwag_tb;
  import hwag_pkg::*;

  logic        clk;
  logic        rst_n;
  reg_req_t    req;
  logic [15:0] rdata;
  logic        vr_in;
  logic        vr_out;
  logic        hwag_start;
  logic        irq;
  logic        ign_out;

  int errors;
  int checks;
  int flt_len;
  int glitch_len;
  int pulse_len;
  int min_per;
  int max_per;
  int teeth_num;
  int ang_shift;
  int ign_on;
  int ign_off;
  int period;
  int jitter;
  int ign_revs;
  int cnt_reads;
  int exp_per;
  int exp_high;

  // Wheel generator state
  int     jitter_cur;
  bit     wheel_on;
  bit     extra_gap;
  int     last_pos;
  event   gen_gap;

  // Ignition monitor state
  int     rise_cnt;
  int     high_len;
  logic   ign_q;
  logic   start_q;
  bit     setup_done;
  longint watch_cycles;

  hwag #(.PER_W(12), .ANG_W(24)) hwag_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .rdata      (rdata),
    .vr_in      (vr_in),
    .vr_out     (vr_out),
    .hwag_start (hwag_start),
    .irq        (irq),
    .ign_out    (ign_out)
  );

  always #50 clk = ~clk;

  task automatic check_value(input longint actual, input longint expected, input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s (got %0d, expected %0d)", $time, msg, actual,
               expected);
    end
  endtask

  task automatic reg_write(input reg_addr_e addr, input logic [15:0] data);
    @(posedge clk);
    req <= {1'b1, 1'b0, 8'(addr), data};
    @(posedge clk);
    req <= '0;
  endtask

  // Data is registered on the cycle after re
  task automatic reg_read(input reg_addr_e addr, output logic [15:0] data);
    @(posedge clk);
    req <= {1'b0, 1'b1, 8'(addr), 16'd0};
    @(posedge clk);
    req <= '0;
    @(posedge clk);
    data = rdata;
  endtask

  task automatic write_pair(input reg_addr_e lo, input reg_addr_e hi, input int value);
    reg_write(lo, value[15:0]);
    reg_write(hi, {8'd0, value[23:16]});
  endtask

  task automatic read_pair(input reg_addr_e lo, input reg_addr_e hi, output int value);
    logic [15:0] l;
    logic [15:0] h;
    reg_read(lo, l);
    reg_read(hi, h);
    value = {h[7:0], l};
  endtask

  task automatic wait_start(input logic level, input int max_cycles, output bit ok);
    ok = 0;
    for (int i = 0; i < max_cycles && !ok; i++) begin
      @(posedge clk);
      if (hwag_start === level) ok = 1;
    end
  endtask

  // Drives a pulse on vr_in and reports whether vr_out followed it
  task automatic pulse_seen(input int len, output bit seen);
    seen = 0;
    @(posedge clk);
    vr_in <= 1'b1;
    repeat (len) begin
      @(posedge clk);
      if (vr_out) seen = 1;
    end
    vr_in <= 1'b0;
    repeat (flt_len + 10) begin
      @(posedge clk);
      if (vr_out) seen = 1;
    end
  endtask

  task automatic load_settings(output bit ok);
    int fd;
    int code;
    int val;
    logic [8*80-1:0]  line;
    logic [8*16-1:0]  key;
    ok = 0;
    fd = $fopen("verif/hwag_input.txt", "r");
    if (fd != 0) begin
      ok = 1;
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && $sscanf(line, "%s %d", key, val) == 2) begin
          case (key)
            "flt_len":    flt_len = val;
            "glitch_len": glitch_len = val;
            "pulse_len":  pulse_len = val;
            "min_per":    min_per = val;
            "max_per":    max_per = val;
            "teeth_num":  teeth_num = val;
            "ang_shift":  ang_shift = val;
            "ign_on":     ign_on = val;
            "ign_off":    ign_off = val;
            "period":     period = val;
            "jitter":     jitter = val;
            "ign_revs":   ign_revs = val;
            "cnt_reads":  cnt_reads = val;
            "exp_per":    exp_per = val;
            "exp_high":   exp_high = val;
            default:      $display("Unknown setting in input file ignored");
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // The last tooth spans three periods and pos 0 follows the gap
  initial begin : wheel_gen
    int pos;
    int p;
    int len;
    pos = 0;
    forever begin
      wait (wheel_on);
      @(posedge clk);
      while (wheel_on) begin
        p = period;
        if (jitter_cur > 0) p = period + int'($urandom % (jitter_cur + 1));
        len = (pos == teeth_num - 1) ? 3 * p : p;
        if (extra_gap && pos == 3) begin
          len = 3 * p;
          extra_gap = 0;
        end
        last_pos = pos;
        if (pos == 0) -> gen_gap;
        vr_in <= 1'b1;
        repeat (p / 2) @(posedge clk);
        vr_in <= 1'b0;
        repeat (len - p / 2) @(posedge clk);
        pos = (pos + 1) % teeth_num;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      // One cycle of lag is allowed while the output register follows
      if (!hwag_start && !start_q) check_value(ign_out, 0, "ign_out high without sync");
      if (ign_out && !ign_q) rise_cnt++;
      if (ign_out) begin
        high_len++;
      end else if (high_len > 0) begin
        if (hwag_start) begin
          check_value(high_len >= exp_high - period && high_len <= exp_high + period, 1,
                      "ignition high time");
        end
        high_len = 0;
      end
    end
    ign_q   = ign_out;
    start_q = hwag_start;
  end

  initial begin : watchdog
    wait (setup_done);
    repeat (watch_cycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", watch_cycles);
    $display(">>> FAIL");
    $finish;
  end

  task automatic run_tests();
    logic [15:0] d;
    int   v;
    int   pos;
    int   rev;
    bit   ok;
    bit   seen;
    rev = (teeth_num + 2) * (period + jitter);

    // Register readback and set/clear control
    reg_write(FLT_LEN, flt_len[15:0]);
    write_pair(MIN_PER_L, MIN_PER_H, min_per);
    write_pair(MAX_PER_L, MAX_PER_H, max_per);
    reg_write(TEETH_NUM, teeth_num[15:0]);
    reg_write(ANG_SHIFT, ang_shift[15:0]);
    write_pair(IGN_ON_L, IGN_ON_H, ign_on);
    write_pair(IGN_OFF_L, IGN_OFF_H, ign_off);
    reg_read(FLT_LEN, d);
    check_value(d, flt_len, "FLT_LEN readback");
    read_pair(MIN_PER_L, MIN_PER_H, v);
    check_value(v, min_per, "MIN_PER readback");
    read_pair(MAX_PER_L, MAX_PER_H, v);
    check_value(v, max_per, "MAX_PER readback");
    reg_read(TEETH_NUM, d);
    check_value(d, teeth_num, "TEETH_NUM readback");
    reg_read(ANG_SHIFT, d);
    check_value(d, ang_shift, "ANG_SHIFT readback");
    read_pair(IGN_ON_L, IGN_ON_H, v);
    check_value(v, ign_on, "IGN_ON readback");
    read_pair(IGN_OFF_L, IGN_OFF_H, v);
    check_value(v, ign_off, "IGN_OFF readback");
    reg_write(CTRL_SET, 16'h0006);
    reg_read(CTRL_SET, d);
    check_value(d, 6, "CTRL after set");
    reg_write(CTRL_CLR, 16'h0002);
    reg_read(CTRL_CLR, d);
    check_value(d, 4, "CTRL after clear");
    reg_write(IE_SET, 16'h000f);
    reg_write(IE_CLR, 16'h0001);
    reg_read(IE_SET, d);
    check_value(d, 14, "IE after set and clear");

    // Glitch filter
    pulse_seen(glitch_len, seen);
    check_value(seen, 0, "short glitch reached vr_out");
    pulse_seen(pulse_len, seen);
    check_value(seen, 1, "long pulse missing at vr_out");

    // Lock on the first gap
    reg_write(CTRL_SET, 16'h0001);
    reg_read(CTRL_SET, d);
    check_value(d, 5, "CTRL with capture on");
    jitter_cur = 0;
    wheel_on   = 1;
    wait_start(1'b1, 3 * rev, ok);
    if (!ok) begin
      errors++;
      $display("hwag_start did not rise after the first gap");
    end
    check_value(last_pos, 0, "lock point is the gap tooth");

    // Stable tooth period
    wait (last_pos == 3);
    repeat (period / 2) @(posedge clk);
    read_pair(PER_L, PER_H, v);
    check_value(v, exp_per, "PER after stable tooth");

    // Tooth count at random times
    jitter_cur = jitter;
    for (int i = 0; i < cnt_reads; i++) begin
      repeat (20 + $urandom % 200) @(posedge clk);
      pos = last_pos;
      reg_read(TOOTH_CNT, d);
      v = (pos - int'(d) + teeth_num) % teeth_num;
      check_value(v <= 1, 1, "TOOTH_CNT within one tooth");
    end

    // Ignition rises once per revolution
    @(gen_gap);
    rise_cnt = 0;
    repeat (ign_revs) @(gen_gap);
    check_value(rise_cnt, ign_revs, "ignition pulses per revolution");

    // Gap point flag off so irq follows the gap error alone
    reg_write(IE_CLR, 16'h0004);
    reg_write(IFR, 16'h000f);
    reg_read(IFR, d);
    check_value(d, 0, "IFR cleared before extra gap");
    check_value(irq, 0, "irq low before extra gap");

    // Extra gap in the wrong place
    extra_gap = 1;
    wait_start(1'b0, 3 * rev, ok);
    check_value(ok, 1, "hwag_start dropped after extra gap");
    repeat (3) @(posedge clk);
    check_value(irq, 1, "irq after gap error");
    reg_read(IFR, d);
    check_value(d[3], 1, "gap error flag set");
    reg_write(IFR, 16'h0008);
    reg_read(IFR, d);
    check_value(d[3], 0, "gap error flag cleared");
    wait_start(1'b1, 3 * rev, ok);
    check_value(ok, 1, "relock after gap error");

    // Stopped wheel overflows the period counter
    wheel_on = 0;
    seen = 0;
    for (int i = 0; i < 100 && !seen; i++) begin
      repeat (50) @(posedge clk);
      reg_read(IFR, d);
      seen = d[1];
    end
    check_value(seen, 1, "overflow flag after wheel stop");
    check_value(hwag_start, 0, "hwag_start low after overflow");
  endtask

  initial begin : main
    int  rnd;
    bit  ok;
    clk        = 1'b0;
    rst_n      = 1'b0;
    req        = '0;
    vr_in      = 1'b0;
    errors     = 0;
    checks     = 0;
    wheel_on   = 0;
    extra_gap  = 0;
    jitter_cur = 0;
    last_pos   = 0;
    rise_cnt   = 0;
    high_len   = 0;
    ign_q      = 1'b0;
    start_q    = 1'b0;
    rnd = $urandom(32'h6511f9b9);
    load_settings(ok);
    if (!ok) begin
      $display("Could not open verif/hwag_input.txt");
      $display(">>> FAIL");
      $finish;
    end else begin
      // Twice the generated wheel time plus a fixed margin
      watch_cycles = 2 * (longint'((teeth_num + 2) * (period + jitter)) * (ign_revs + 12)
                     + 4096) + 10000;
      setup_done = 1;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      run_tests();
      $display("Run complete: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
        $display(">>> PASS");
      end else begin
        $display(">>> FAIL");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog/angle_gen.sv
// Sub-tooth interpolation: splits each tooth period into 2^ang_shift angle ticks
// Angle is reloaded per tooth and restarts at zero on the gap point
`timescale 1ns/1ps
`default_nettype none

module angle_gen #(
  parameter int PER_W = 24,
  parameter int ANG_W = 24
) (
  input  logic                clk,
  input  logic                rst_n,
  input  hwag_pkg::hwag_cfg_t cfg,
  input  logic                tooth_edge,
  input  logic                sync_restart,
  input  logic                hwag_start,
  input  logic                gap_point,
  input  logic [PER_W-1:0]    period,
  output logic [ANG_W-1:0]    angle
);

  localparam int TICK_W = 18;

  logic              edge_d;
  logic [7:0]        tooth_idx;
  logic [7:0]        idx_nxt;
  logic              gap_tooth;
  logic [PER_W-1:0]  step_top;
  logic [PER_W-1:0]  step_cnt;
  logic              step_wrap;
  logic [TICK_W-1:0] tick_cnt;
  logic [TICK_W-1:0] tick_lim;
  logic              tick;

  // Period and gap_point are valid one cycle after the edge
  assign idx_nxt   = (sync_restart || gap_point) ? 8'd0 : tooth_idx + 8'd1;
  assign tick_lim  = gap_tooth ? (TICK_W'(3) << cfg.ang_shift) : (TICK_W'(1) << cfg.ang_shift);
  assign step_wrap = (step_cnt + 1'b1) >= step_top;
  assign tick      = hwag_start && !edge_d && tick_cnt != tick_lim && step_wrap;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      edge_d    <= 1'b0;
      tooth_idx <= '0;
      gap_tooth <= 1'b0;
      step_cnt  <= '0;
      tick_cnt  <= '0;
      angle     <= '0;
    end else begin
      edge_d <= tooth_edge;
      if (!hwag_start) begin
        tooth_idx <= '0;
        gap_tooth <= 1'b0;
        step_cnt  <= '0;
        tick_cnt  <= '0;
        angle     <= '0;
      end else if (edge_d) begin
        tooth_idx <= idx_nxt;
        gap_tooth <= idx_nxt == cfg.teeth_num - 8'd1;
        step_cnt  <= '0;
        tick_cnt  <= '0;
        angle     <= ANG_W'(idx_nxt) << cfg.ang_shift;
      end else if (tick_cnt != tick_lim) begin
        step_cnt <= step_wrap ? '0 : step_cnt + 1'b1;
        if (tick) begin
          tick_cnt <= tick_cnt + 1'b1;
          angle    <= angle + 1'b1;
        end
      end
    end
  end

  // Gap period is three teeth long, keep the last normal step
  always_ff @(posedge clk) begin
    if (edge_d && !sync_restart && !gap_point) begin
      step_top <= period >> cfg.ang_shift;
    end
  end

endmodule

`default_nettype wire

// File: verilog/hwag.sv
// Angle generator top: register port, sensor front end, crank sync and ignition
// Counter widths are set here and passed down
`timescale 1ns/1ps
`default_nettype none

module hwag #(
  parameter int PER_W = 24,
  parameter int ANG_W = 24
) (
  input  logic               clk,
  input  logic               rst_n,
  input  hwag_pkg::reg_req_t req,
  output logic [15:0]        rdata,
  input  logic               vr_in,
  output logic               vr_out,
  output logic               hwag_start,
  output logic               irq,
  output logic               ign_out
);
  import hwag_pkg::*;

  hwag_cfg_t        cfg;
  hwag_evt_t        evt;
  logic             tooth_edge;
  logic             sync_restart;
  logic [PER_W-1:0] period;
  logic [7:0]       tooth_cnt;
  logic [ANG_W-1:0] angle;

  hwag_regs regs_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .rdata     (rdata),
    .cfg       (cfg),
    .evt       (evt),
    .period    (24'(period)),
    .tooth_cnt (tooth_cnt),
    .angle     (24'(angle)),
    .irq       (irq)
  );

  // Opposite edge is not needed by the sync path
  vr_capture capture_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .vr_in         (vr_in),
    .cfg           (cfg),
    .vr_out        (vr_out),
    .tooth_edge    (tooth_edge),
    .opposite_edge ()
  );

  tooth_timing #(.PER_W(PER_W)) timing_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .tooth_edge   (tooth_edge),
    .evt          (evt),
    .period       (period),
    .tooth_cnt    (tooth_cnt),
    .hwag_start   (hwag_start),
    .sync_restart (sync_restart)
  );

  angle_gen #(.PER_W(PER_W), .ANG_W(ANG_W)) angle_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .tooth_edge   (tooth_edge),
    .sync_restart (sync_restart),
    .hwag_start   (hwag_start),
    .gap_point    (evt.gap_point),
    .period       (period),
    .angle        (angle)
  );

  ign_output #(.ANG_W(ANG_W)) ign_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .hwag_start (hwag_start),
    .angle      (angle),
    .ign_out    (ign_out)
  );

endmodule

`default_nettype wire

// File: verilog/hwag_pkg.sv
// Shared types for the angle generator: register map, host port, settings and events
// Compile before the RTL; modules import it in their bodies where needed
`default_nettype none

package hwag_pkg;

  // Host register map, 16-bit data per address
  typedef enum logic [7:0] {
    CTRL_SET  = 8'h00,
    CTRL_CLR  = 8'h01,
    IE_SET    = 8'h02,
    IE_CLR    = 8'h03,
    IFR       = 8'h04,
    FLT_LEN   = 8'h05,
    MIN_PER_L = 8'h06,
    MIN_PER_H = 8'h07,
    MAX_PER_L = 8'h08,
    MAX_PER_H = 8'h09,
    TEETH_NUM = 8'h0a,
    ANG_SHIFT = 8'h0b,
    TOOTH_CNT = 8'h0c,
    PER_L     = 8'h0d,
    PER_H     = 8'h0e,
    ANGLE_L   = 8'h0f,
    ANGLE_H   = 8'h10,
    IGN_ON_L  = 8'h11,
    IGN_ON_H  = 8'h12,
    IGN_OFF_L = 8'h13,
    IGN_OFF_H = 8'h14
  } reg_addr_e;

  typedef struct packed {
    logic        we;
    logic        re;
    logic [7:0]  addr;
    logic [15:0] wdata;
  } reg_req_t;

  // Decoded settings, control bits first
  typedef struct packed {
    logic        cap_en;
    logic        edge_sel;
    logic        flt_en;
    logic [15:0] flt_len;
    logic [23:0] min_per;
    logic [23:0] max_per;
    logic [7:0]  teeth_num;
    logic [3:0]  ang_shift;
    logic [23:0] ign_on;
    logic [23:0] ign_off;
  } hwag_cfg_t;

  typedef struct packed {
    logic tooth_edge;
    logic per_ovf;
    logic gap_point;
    logic gap_error;
  } hwag_evt_t;

  typedef enum logic [1:0] {
    SYNC_OFF,
    SYNC_SEARCH,
    SYNC_RUN
  } sync_state_e;

endpackage

`default_nettype wire

// File: verilog/hwag_regs.sv
// Host register bank: settings, set/clear control and interrupt registers, read port
// Flags latch enabled events; irq stays high while any flag is set
`timescale 1ns/1ps
`default_nettype none

module hwag_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  hwag_pkg::reg_req_t  req,
  output logic [15:0]         rdata,
  output hwag_pkg::hwag_cfg_t cfg,
  input  hwag_pkg::hwag_evt_t evt,
  input  logic [23:0]         period,
  input  logic [7:0]          tooth_cnt,
  input  logic [23:0]         angle,
  output logic                irq
);
  import hwag_pkg::*;

  reg_addr_e   addr;
  logic [3:0]  ie;
  logic [3:0]  ifr;
  logic [3:0]  evt_vec;
  logic [3:0]  ifr_clr;
  logic [15:0] wr_low;
  logic [7:0]  per_snap;
  logic [7:0]  ang_snap;
  logic [15:0] rd_mux;

  assign addr = reg_addr_e'(req.addr);

  // Bit 0 tooth edge, 1 overflow, 2 gap point, 3 gap error
  assign evt_vec = {evt.gap_error, evt.gap_point, evt.per_ovf, evt.tooth_edge};
  assign ifr_clr = (req.we && addr == IFR) ? req.wdata[3:0] : 4'd0;
  assign irq     = |ifr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;
      ie  <= '0;
      ifr <= '0;
    end else begin
      ifr <= (ifr & ~ifr_clr) | (evt_vec & ie);
      if (req.we) begin
        case (addr)
          CTRL_SET:  {cfg.flt_en, cfg.edge_sel, cfg.cap_en} <=
                       {cfg.flt_en, cfg.edge_sel, cfg.cap_en} | req.wdata[2:0];
          CTRL_CLR:  {cfg.flt_en, cfg.edge_sel, cfg.cap_en} <=
                       {cfg.flt_en, cfg.edge_sel, cfg.cap_en} & ~req.wdata[2:0];
          IE_SET:    ie <= ie | req.wdata[3:0];
          IE_CLR:    ie <= ie & ~req.wdata[3:0];
          FLT_LEN:   cfg.flt_len <= req.wdata;
          // High half commits the pair
          MIN_PER_H: cfg.min_per <= {req.wdata[7:0], wr_low};
          MAX_PER_H: cfg.max_per <= {req.wdata[7:0], wr_low};
          TEETH_NUM: cfg.teeth_num <= req.wdata[7:0];
          ANG_SHIFT: cfg.ang_shift <= req.wdata[3:0];
          IGN_ON_H:  cfg.ign_on <= {req.wdata[7:0], wr_low};
          IGN_OFF_H: cfg.ign_off <= {req.wdata[7:0], wr_low};
          default:   ;
        endcase
      end
    end
  end

  // Low half holding register, shared by all 24-bit settings
  always_ff @(posedge clk) begin
    if (req.we && (addr == MIN_PER_L || addr == MAX_PER_L ||
                   addr == IGN_ON_L || addr == IGN_OFF_L)) begin
      wr_low <= req.wdata;
    end
  end

  always_comb begin
    rd_mux = '0;
    case (addr)
      CTRL_SET, CTRL_CLR: rd_mux = {13'd0, cfg.flt_en, cfg.edge_sel, cfg.cap_en};
      IE_SET, IE_CLR:     rd_mux = {12'd0, ie};
      IFR:                rd_mux = {12'd0, ifr};
      FLT_LEN:            rd_mux = cfg.flt_len;
      MIN_PER_L:          rd_mux = cfg.min_per[15:0];
      MIN_PER_H:          rd_mux = {8'd0, cfg.min_per[23:16]};
      MAX_PER_L:          rd_mux = cfg.max_per[15:0];
      MAX_PER_H:          rd_mux = {8'd0, cfg.max_per[23:16]};
      TEETH_NUM:          rd_mux = {8'd0, cfg.teeth_num};
      ANG_SHIFT:          rd_mux = {12'd0, cfg.ang_shift};
      TOOTH_CNT:          rd_mux = {8'd0, tooth_cnt};
      PER_L:              rd_mux = period[15:0];
      PER_H:              rd_mux = {8'd0, per_snap};
      ANGLE_L:            rd_mux = angle[15:0];
      ANGLE_H:            rd_mux = {8'd0, ang_snap};
      IGN_ON_L:           rd_mux = cfg.ign_on[15:0];
      IGN_ON_H:           rd_mux = {8'd0, cfg.ign_on[23:16]};
      IGN_OFF_L:          rd_mux = cfg.ign_off[15:0];
      IGN_OFF_H:          rd_mux = {8'd0, cfg.ign_off[23:16]};
      default:            rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else if (req.re) begin
      rdata <= rd_mux;
    end
  end

  // Low half read freezes the high half for the following read
  always_ff @(posedge clk) begin
    if (req.re && addr == PER_L) begin
      per_snap <= period[23:16];
    end
    if (req.re && addr == ANGLE_L) begin
      ang_snap <= angle[23:16];
    end
  end

endmodule

`default_nettype wire

// File: verilog/ign_output.sv
// Ignition driver: output high from the ign_on angle up to the ign_off angle
// Held low whenever the angle is not synchronized
`timescale 1ns/1ps
`default_nettype none

module ign_output #(
  parameter int ANG_W = 24
) (
  input  logic                clk,
  input  logic                rst_n,
  input  hwag_pkg::hwag_cfg_t cfg,
  input  logic                hwag_start,
  input  logic [ANG_W-1:0]    angle,
  output logic                ign_out
);

  logic [ANG_W-1:0] on_ang;
  logic [ANG_W-1:0] off_ang;

  assign on_ang  = ANG_W'(cfg.ign_on);
  assign off_ang = ANG_W'(cfg.ign_off);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ign_out <= 1'b0;
    end else if (!hwag_start) begin
      ign_out <= 1'b0;
    end else if (angle == off_ang) begin
      ign_out <= 1'b0;   // off wins if both angles are equal
    end else if (angle == on_ang) begin
      ign_out <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/tooth_timing.sv
// Tooth period measurement, gap search and crank sync state machine
// Period, tooth count and events update the cycle after each tooth edge
`timescale 1ns/1ps
`default_nettype none

module tooth_timing #(
  parameter int PER_W = 24
) (
  input  logic                clk,
  input  logic                rst_n,
  input  hwag_pkg::hwag_cfg_t cfg,
  input  logic                tooth_edge,
  output hwag_pkg::hwag_evt_t evt,
  output logic [PER_W-1:0]    period,
  output logic [7:0]          tooth_cnt,
  output logic                hwag_start,
  output logic                sync_restart
);
  import hwag_pkg::*;

  localparam logic [PER_W-1:0] PER_LAST = {PER_W{1'b1}} - 1'b1;

  sync_state_e      state;
  sync_state_e      state_nxt;
  logic [PER_W-1:0] per_cnt;
  logic [PER_W-1:0] per_old;
  logic [PER_W-1:0] min_per;
  logic [PER_W-1:0] max_per;
  logic             running;
  logic             ovf_now;
  logic             gap_now;
  logic             at_wrap;
  logic             gap_pt;
  logic             gap_err;

  assign min_per = PER_W'(cfg.min_per);
  assign max_per = PER_W'(cfg.max_per);
  assign ovf_now = running && !tooth_edge && per_cnt == PER_LAST;
  assign at_wrap = tooth_cnt == cfg.teeth_num - 8'd1;

  // Live count against the two stored periods
  assign gap_now = running && ({1'b0, per_cnt} >= {period, 1'b0}) &&
                   period >= min_per && period <= max_per &&
                   per_old >= min_per && per_old <= max_per;

  always_comb begin
    state_nxt = state;
    gap_pt    = 1'b0;
    gap_err   = 1'b0;
    if (!cfg.cap_en) begin
      state_nxt = SYNC_OFF;
    end else begin
      case (state)
        SYNC_OFF:    state_nxt = SYNC_SEARCH;
        SYNC_SEARCH: if (tooth_edge && gap_now) state_nxt = SYNC_RUN;
        SYNC_RUN: begin
          if (ovf_now) begin
            state_nxt = SYNC_SEARCH;
          end else if (tooth_edge) begin
            if (at_wrap && gap_now) begin
              gap_pt = 1'b1;
            end else if (at_wrap || gap_now) begin
              gap_err   = 1'b1;
              state_nxt = SYNC_SEARCH;
            end
          end
        end
        default:     state_nxt = SYNC_OFF;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= SYNC_OFF;
      running      <= 1'b0;
      per_cnt      <= '0;
      period       <= '0;
      per_old      <= '0;
      tooth_cnt    <= '0;
      sync_restart <= 1'b0;
      evt          <= '0;
    end else begin
      state        <= state_nxt;
      sync_restart <= state == SYNC_SEARCH && state_nxt == SYNC_RUN;
      evt          <= '{tooth_edge: tooth_edge, per_ovf: ovf_now,
                        gap_point: gap_pt, gap_error: gap_err};
      // Overflow and disable both drop the history
      if (!cfg.cap_en || ovf_now) begin
        running <= 1'b0;
        per_cnt <= '0;
        period  <= '0;
        per_old <= '0;
      end else if (tooth_edge) begin
        running <= 1'b1;
        per_cnt <= PER_W'(1);
        if (running) begin
          period  <= per_cnt;
          per_old <= period;
        end
      end else if (running) begin
        per_cnt <= per_cnt + 1'b1;
      end
      if (state_nxt != SYNC_RUN || state != SYNC_RUN || gap_pt) begin
        tooth_cnt <= '0;
      end else if (tooth_edge) begin
        tooth_cnt <= tooth_cnt + 8'd1;
      end
    end
  end

  assign hwag_start = state == SYNC_RUN;

endmodule

`default_nettype wire

// File: verilog/vr_capture.sv
// Sensor front end: two-flop synchronizer, glitch filter and edge select
// Delay from pin to vr_out is flt_len plus 3 clocks on both edges
`timescale 1ns/1ps
`default_nettype none

module vr_capture (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                vr_in,
  input  hwag_pkg::hwag_cfg_t cfg,
  output logic                vr_out,
  output logic                tooth_edge,
  output logic                opposite_edge
);

  logic [1:0]  sync_q;
  logic        filt_q;
  logic        filt_d;
  logic [15:0] flt_cnt;
  logic        rise;
  logic        fall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q  <= '0;
      filt_q  <= 1'b0;
      filt_d  <= 1'b0;
      flt_cnt <= '0;
    end else begin
      sync_q <= {sync_q[0], vr_in};
      filt_d <= filt_q;
      // Level must differ for flt_len clocks before it is taken
      if (!cfg.flt_en || sync_q[1] == filt_q) begin
        flt_cnt <= '0;
        filt_q  <= sync_q[1];
      end else if (flt_cnt == cfg.flt_len) begin
        flt_cnt <= '0;
        filt_q  <= sync_q[1];
      end else begin
        flt_cnt <= flt_cnt + 16'd1;
      end
    end
  end

  assign vr_out = filt_q;
  assign rise   = filt_q & ~filt_d;
  assign fall   = ~filt_q & filt_d;

  // edge_sel high picks the falling edge as the tooth edge
  assign tooth_edge    = cfg.cap_en & (cfg.edge_sel ? fall : rise);
  assign opposite_edge = cfg.cap_en & (cfg.edge_sel ? rise : fall);

endmodule

`default_nettype wire
